/* common/decodePkg.sv */
`default_nettype none

package decodePkg;

    localparam int instrW = 32;
    localparam int pcW = 64;

    // major opcode, taken from instr[6:2]
    typedef enum logic [4:0] {
        clsLoad    = 5'b00000,
        clsFence   = 5'b00011,
        clsOpImm   = 5'b00100,
        clsAuipc   = 5'b00101,
        clsOpImm32 = 5'b00110,
        clsStore   = 5'b01000,
        clsOp      = 5'b01100,
        clsLui     = 5'b01101,
        clsOp32    = 5'b01110,
        clsBranch  = 5'b11000,
        clsJalr    = 5'b11001,
        clsJal     = 5'b11011,
        clsSystem  = 5'b11100
    } opClassE;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immJ = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immU = 3'b101
    } extOpE;

    // bltu and bgeu share blt/bge, unsigned compare comes from aluCtl
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brBeq  = 3'b100,
        brBne  = 3'b101,
        brBlt  = 3'b110,
        brBge  = 3'b111
    } branchE;

    typedef enum logic [2:0] {
        sysNone,
        sysEcall,
        sysEbreak,
        sysMret,
        sysFenceI
    } sysOpE;

    typedef enum logic [1:0] {
        srcRs2  = 2'd0,
        srcFour = 2'd1,
        srcImm  = 2'd2,
        srcCsr  = 2'd3
    } aluSrcBE;

    typedef struct packed {
        opClassE     opClass;
        extOpE       extOp;
        logic [5:0]  aluCtl;  // [5] muldiv, [4] word op
        logic        aluSrcA; // pc instead of rs1
        aluSrcBE     aluSrcB;
        branchE      branch;
        logic        regWr;
        logic        memRd;
        logic        memWr;
        logic [2:0]  memOp;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] csrAddr;
        logic [31:0] imm;
        sysOpE       sysOp;
        logic        fetchErr;
        logic        illegal;
    } uopT;

endpackage

`default_nettype wire

/* common/instrIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface instrIf;

    logic valid;
    logic ready;
    logic [decodePkg::instrW-1:0] instr;
    logic [decodePkg::pcW-1:0] pc;
    logic fetchErr;

    modport source (output valid, output instr, output pc, output fetchErr, input ready);
    modport sink (input valid, input instr, input pc, input fetchErr, output ready);

endinterface

`default_nettype wire

/* common/uopIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface uopIf;

    logic valid;
    logic ready;
    logic [decodePkg::pcW-1:0] pc;
    decodePkg::uopT uop;

    modport source (output valid, output pc, output uop, input ready);
    modport sink (input valid, input pc, input uop, output ready);

endinterface

`default_nettype wire

/* hw/decodeLane/immGen.sv */
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  logic [decodePkg::instrW-1:0] instr,
    input  decodePkg::extOpE             extOp,
    output logic [31:0]                  imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (extOp)
            decodePkg::immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            decodePkg::immB: imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            decodePkg::immU: imm = {instr[31:12], 12'b0};
            decodePkg::immJ: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = {{20{sign}}, instr[31:20]}; // I format
        endcase
    end

endmodule

`default_nettype wire

/* hw/decodeLane/controlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecode (
    input  logic [decodePkg::instrW-1:0] instr,
    output decodePkg::opClassE           opClass,
    output decodePkg::extOpE             extOp,
    output logic [5:0]                   aluCtl,
    output logic                         aluSrcA,
    output decodePkg::aluSrcBE           aluSrcB,
    output decodePkg::branchE            branch,
    output logic                         regWr,
    output logic                         memRd,
    output logic                         memWr,
    output logic [2:0]                   memOp,
    output logic                         illegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [3:0] aluLow;
    logic err;
    logic isRType;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign opClass = decodePkg::opClassE'(instr[6:2]);
    assign isRType = (opClass == decodePkg::clsOp) || (opClass == decodePkg::clsOp32);

    assign memOp = funct3;
    assign memRd = opClass == decodePkg::clsLoad;
    assign memWr = opClass == decodePkg::clsStore;
    assign regWr = (opClass != decodePkg::clsBranch) && (opClass != decodePkg::clsStore);
    assign aluSrcA = (opClass == decodePkg::clsAuipc) || (opClass == decodePkg::clsJal) ||
                     (opClass == decodePkg::clsJalr);
    assign aluCtl = {isRType && funct7[0], instr[3] & ~instr[2], aluLow};
    assign illegal = err || (instr[1:0] != 2'b11);

    always_comb begin
        extOp = decodePkg::immI;
        aluSrcB = decodePkg::srcRs2;
        aluLow = 4'b0000;
        branch = decodePkg::brNone;
        err = 1'b0;
        case (opClass)
            decodePkg::clsFence: ; // fence.i check sits in the lane
            decodePkg::clsSystem: begin
                aluSrcB = decodePkg::srcCsr;
                aluLow = 4'b1111;
                err = funct3 == 3'b100;
            end
            decodePkg::clsLui: begin
                extOp = decodePkg::immU;
                aluSrcB = decodePkg::srcImm;
                aluLow = 4'b1111; // pass b
            end
            decodePkg::clsAuipc: begin
                extOp = decodePkg::immU;
                aluSrcB = decodePkg::srcImm;
            end
            decodePkg::clsJal: begin
                extOp = decodePkg::immJ;
                aluSrcB = decodePkg::srcFour; // link = pc + 4
                branch = decodePkg::brJal;
            end
            decodePkg::clsJalr: begin
                aluSrcB = decodePkg::srcFour;
                branch = decodePkg::brJalr;
                err = funct3 != 3'b000;
            end
            decodePkg::clsBranch: begin
                extOp = decodePkg::immB;
                aluLow = funct3[1] ? 4'b0011 : 4'b0010; // unsigned compare for bltu/bgeu
                case (funct3)
                    3'b000: branch = decodePkg::brBeq;
                    3'b001: branch = decodePkg::brBne;
                    3'b100, 3'b110: branch = decodePkg::brBlt;
                    3'b101, 3'b111: branch = decodePkg::brBge;
                    default: begin
                        aluLow = 4'b0000;
                        err = 1'b1;
                    end
                endcase
            end
            decodePkg::clsLoad: begin
                aluSrcB = decodePkg::srcImm;
                err = funct3 == 3'b111;
            end
            decodePkg::clsStore: begin
                extOp = decodePkg::immS;
                aluSrcB = decodePkg::srcImm;
                err = funct3[2];
            end
            decodePkg::clsOpImm: begin
                aluSrcB = decodePkg::srcImm;
                aluLow = {funct7[5] && (funct3 == 3'b101), funct3};
                err = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000)) ||
                      ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000) &&
                       (funct7[6:1] != 6'b010000));
            end
            decodePkg::clsOpImm32: begin
                aluSrcB = decodePkg::srcImm;
                aluLow = {funct7[5] && (funct3 == 3'b101), funct3};
                err = (funct3 != 3'b000) && ((funct3 != 3'b001) || (funct7 != 7'b0000000)) &&
                      ((funct3 != 3'b101) || ((funct7 != 7'b0000000) && (funct7 != 7'b0100000)));
            end
            decodePkg::clsOp: begin
                extOp = decodePkg::immS;
                aluLow = {funct7[5], funct3};
                err = !((funct7 == 7'b0000000) || (funct7 == 7'b0000001) ||
                        ((funct7 == 7'b0100000) &&
                         (funct3 == 3'b000 || funct3 == 3'b101))); // sub, sra only
            end
            decodePkg::clsOp32: begin
                extOp = decodePkg::immS;
                aluLow = {funct7[5], funct3};
                err = !(((funct7 == 7'b0000000) &&
                         (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101)) ||
                        ((funct7 == 7'b0000001) && (funct3 == 3'b000 || funct3[2])));
            end
            default: err = 1'b1; // unlisted opcode
        endcase
    end

endmodule

`default_nettype wire

/* hw/decodeLane/decodeLane.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeLane (
    input logic  clk,
    input logic  rstN,
    instrIf.sink in,
    uopIf.source out
);

    decodePkg::opClassE opClass;
    decodePkg::extOpE extOp;
    decodePkg::aluSrcBE aluSrcB;
    decodePkg::branchE branch;
    decodePkg::sysOpE sysOp;
    logic [5:0] aluCtl;
    logic [2:0] memOp;
    logic [31:0] imm;
    logic aluSrcA;
    logic regWr;
    logic memRd;
    logic memWr;
    logic ctlIllegal;
    logic isEcall;
    logic isEbreak;
    logic isMret;
    logic isFenceI;
    logic badSystem;
    logic badFence;
    logic full;
    logic take;
    logic [decodePkg::pcW-1:0] pcQ;
    decodePkg::uopT uopD;
    decodePkg::uopT uopQ;

    controlDecode ctl0 (
        .instr   (in.instr),
        .opClass (opClass),
        .extOp   (extOp),
        .aluCtl  (aluCtl),
        .aluSrcA (aluSrcA),
        .aluSrcB (aluSrcB),
        .branch  (branch),
        .regWr   (regWr),
        .memRd   (memRd),
        .memWr   (memWr),
        .memOp   (memOp),
        .illegal (ctlIllegal)
    );

    immGen imm0 (
        .instr (in.instr),
        .extOp (extOp),
        .imm   (imm)
    );

    assign isEcall = in.instr == 32'h0000_0073;
    assign isEbreak = in.instr == 32'h0010_0073;
    assign isMret = in.instr == 32'h3020_0073;
    assign isFenceI = in.instr == 32'h0000_100f;
    assign badSystem = (opClass == decodePkg::clsSystem) && (in.instr[14:12] == 3'b000) &&
                       !(isEcall || isEbreak || isMret);
    assign badFence = (opClass == decodePkg::clsFence) && !isFenceI; // plain fence too

    always_comb begin
        if (isEcall) begin
            sysOp = decodePkg::sysEcall;
        end else if (isEbreak) begin
            sysOp = decodePkg::sysEbreak;
        end else if (isMret) begin
            sysOp = decodePkg::sysMret;
        end else if (isFenceI) begin
            sysOp = decodePkg::sysFenceI;
        end else begin
            sysOp = decodePkg::sysNone;
        end
    end

    always_comb begin
        uopD.opClass = opClass;
        uopD.extOp = extOp;
        uopD.aluCtl = aluCtl;
        uopD.aluSrcA = aluSrcA;
        uopD.aluSrcB = aluSrcB;
        uopD.branch = branch;
        uopD.regWr = regWr;
        uopD.memRd = memRd;
        uopD.memWr = memWr;
        uopD.memOp = memOp;
        uopD.rd = in.instr[11:7];
        uopD.rs1 = in.instr[19:15];
        uopD.rs2 = in.instr[24:20];
        uopD.csrAddr = in.instr[31:20];
        uopD.imm = imm;
        uopD.sysOp = sysOp;
        uopD.fetchErr = in.fetchErr;
        uopD.illegal = ctlIllegal || badSystem || badFence;
    end

    assign in.ready = !full || out.ready; // empty, or draining this cycle
    assign take = in.valid && in.ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (out.ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pcQ <= in.pc;
            uopQ <= uopD;
        end
    end

    assign out.valid = full;
    assign out.pc = pcQ;
    assign out.uop = uopQ;

endmodule

`default_nettype wire

/* hw/laneDispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module laneDispatch #(
    parameter int numLanes = 2
) (
    input logic    clk,
    input logic    rstN,
    instrIf.sink   up,
    instrIf.source lanes [numLanes]
);

    localparam int ptrW = (numLanes > 1) ? $clog2(numLanes) : 1;

    logic [ptrW-1:0] ptr;
    logic [numLanes-1:0] laneReady;

    for (genvar i = 0; i < numLanes; i++) begin : genLane
        assign lanes[i].valid = up.valid && (ptr == ptrW'(i));
        assign lanes[i].instr = up.instr; // payload broadcast, valid selects
        assign lanes[i].pc = up.pc;
        assign lanes[i].fetchErr = up.fetchErr;
        assign laneReady[i] = lanes[i].ready;
    end

    assign up.ready = laneReady[ptr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ptr <= '0;
        end else if (up.valid && up.ready) begin
            ptr <= (ptr == ptrW'(numLanes - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/laneCollect.sv */
`timescale 1ns/1ps
`default_nettype none

module laneCollect #(
    parameter int numLanes = 2
) (
    input logic  clk,
    input logic  rstN,
    uopIf.sink   lanes [numLanes],
    uopIf.source down
);

    localparam int ptrW = (numLanes > 1) ? $clog2(numLanes) : 1;

    logic [ptrW-1:0] ptr;
    logic [numLanes-1:0] laneValid;
    logic [decodePkg::pcW-1:0] lanePc [numLanes];
    decodePkg::uopT laneUop [numLanes];

    for (genvar i = 0; i < numLanes; i++) begin : genLane
        assign laneValid[i] = lanes[i].valid;
        assign lanePc[i] = lanes[i].pc;
        assign laneUop[i] = lanes[i].uop;
        assign lanes[i].ready = down.ready && (ptr == ptrW'(i));
    end

    // same walk as the dispatcher, so program order comes back
    assign down.valid = laneValid[ptr];
    assign down.pc = lanePc[ptr];
    assign down.uop = laneUop[ptr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ptr <= '0;
        end else if (down.valid && down.ready) begin
            ptr <= (ptr == ptrW'(numLanes - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/decodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeTop #(
    parameter int numLanes = 2
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         inValid,
    output logic                         inReady,
    input  logic [decodePkg::instrW-1:0] inInstr,
    input  logic [decodePkg::pcW-1:0]    inPc,
    input  logic                         inFetchErr,
    output logic                         outValid,
    input  logic                         outReady,
    output logic [decodePkg::pcW-1:0]    outPc,
    output decodePkg::uopT               outUop
);

    instrIf inBus ();
    uopIf outBus ();
    instrIf laneIn [numLanes] ();
    uopIf laneOut [numLanes] ();

    assign inBus.valid = inValid;
    assign inBus.instr = inInstr;
    assign inBus.pc = inPc;
    assign inBus.fetchErr = inFetchErr;
    assign inReady = inBus.ready;

    assign outValid = outBus.valid;
    assign outPc = outBus.pc;
    assign outUop = outBus.uop;
    assign outBus.ready = outReady;

    laneDispatch #(.numLanes(numLanes)) dispatch0 (
        .clk   (clk),
        .rstN  (rstN),
        .up    (inBus),
        .lanes (laneIn)
    );

    for (genvar g = 0; g < numLanes; g++) begin : genLane
        decodeLane lane (
            .clk  (clk),
            .rstN (rstN),
            .in   (laneIn[g]),
            .out  (laneOut[g])
        );
    end

    laneCollect #(.numLanes(numLanes)) collect0 (
        .clk   (clk),
        .rstN  (rstN),
        .lanes (laneOut),
        .down  (outBus)
    );

endmodule

`default_nettype wire

/* test/decodeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeTb;

    localparam int numTests = 17;
    localparam int resetCycles = 16;
    localparam int timeoutCycles = 40 * numTests + resetCycles;
    localparam logic [63:0] baseAddr = 64'h0000_0000_8000_0000;

    logic clk;
    logic rstN;
    logic inValid;
    logic inReady;
    logic [decodePkg::instrW-1:0] inInstr;
    logic [decodePkg::pcW-1:0] inPc;
    logic inFetchErr;
    logic outValid;
    logic outReady;
    logic [decodePkg::pcW-1:0] outPc;
    decodePkg::uopT outUop;

    // expected values, one row per instruction
    string names [numTests];
    logic [31:0] instrTab [numTests];
    logic fetchTab [numTests];
    logic [4:0] classTab [numTests];
    logic [2:0] extTab [numTests];
    logic [31:0] immTab [numTests];
    logic [4:0] rdTab [numTests];
    logic [2:0] branchTab [numTests];
    logic [2:0] sysTab [numTests];
    logic illegalTab [numTests];

    int fillIdx;
    int accepted;
    int checked;
    int cycleCount = 0;
    int errors = 0;
    logic [15:0] lfsr;

    decodeTop #(.numLanes(3)) dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inReady    (inReady),
        .inInstr    (inInstr),
        .inPc       (inPc),
        .inFetchErr (inFetchErr),
        .outValid   (outValid),
        .outReady   (outReady),
        .outPc      (outPc),
        .outUop     (outUop)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [15:0] stepLfsr(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10]; // x^16 + x^14 + x^13 + x^11 + 1
        return {s[14:0], fb};
    endfunction

    task automatic takeBit(output logic b);
        lfsr = stepLfsr(lfsr);
        b = lfsr[0];
    endtask

    task automatic addEntry(input string name, input logic [31:0] instr, input logic fe,
                            input logic [4:0] cls, input logic [2:0] ext,
                            input logic [31:0] imm, input logic [4:0] rd,
                            input logic [2:0] br, input logic [2:0] sys, input logic ill);
        names[fillIdx] = name;
        instrTab[fillIdx] = instr;
        fetchTab[fillIdx] = fe;
        classTab[fillIdx] = cls;
        extTab[fillIdx] = ext;
        immTab[fillIdx] = imm;
        rdTab[fillIdx] = rd;
        branchTab[fillIdx] = br;
        sysTab[fillIdx] = sys;
        illegalTab[fillIdx] = ill;
        fillIdx++;
    endtask

    task automatic loadTable();
        fillIdx = 0;
        addEntry("addi", 32'hFFD3_0293, 1'b0, decodePkg::clsOpImm, decodePkg::immI,
                 32'hFFFF_FFFD, 5'd5, decodePkg::brNone, decodePkg::sysNone, 1'b0);
        addEntry("sw", 32'h0071_2423, 1'b0, decodePkg::clsStore, decodePkg::immS,
                 32'h0000_0008, 5'd8, decodePkg::brNone, decodePkg::sysNone, 1'b0);
        addEntry("beq", 32'hFE20_8CE3, 1'b0, decodePkg::clsBranch, decodePkg::immB,
                 32'hFFFF_FFF8, 5'd25, decodePkg::brBeq, decodePkg::sysNone, 1'b0);
        addEntry("lui", 32'h1234_5537, 1'b0, decodePkg::clsLui, decodePkg::immU,
                 32'h1234_5000, 5'd10, decodePkg::brNone, decodePkg::sysNone, 1'b0);
        addEntry("jal", 32'hFFDF_F06F, 1'b0, decodePkg::clsJal, decodePkg::immJ,
                 32'hFFFF_FFFC, 5'd0, decodePkg::brJal, decodePkg::sysNone, 1'b0);
        addEntry("badOpcode", 32'h0000_007F, 1'b0, 5'b11111, decodePkg::immI,
                 32'h0000_0000, 5'd0, decodePkg::brNone, decodePkg::sysNone, 1'b1);
        addEntry("loadF3", 32'h0000_7183, 1'b0, decodePkg::clsLoad, decodePkg::immI,
                 32'h0000_0000, 5'd3, decodePkg::brNone, decodePkg::sysNone, 1'b1);
        addEntry("jalrF3", 32'h0001_10E7, 1'b0, decodePkg::clsJalr, decodePkg::immI,
                 32'h0000_0000, 5'd1, decodePkg::brJalr, decodePkg::sysNone, 1'b1);
        // R type is decoded with the S format, so imm holds funct7 and rd
        addEntry("opF7", 32'h4231_00B3, 1'b0, decodePkg::clsOp, decodePkg::immS,
                 32'h0000_0421, 5'd1, decodePkg::brNone, decodePkg::sysNone, 1'b1);
        addEntry("wfi", 32'h1050_0073, 1'b0, decodePkg::clsSystem, decodePkg::immI,
                 32'h0000_0105, 5'd0, decodePkg::brNone, decodePkg::sysNone, 1'b1);
        addEntry("lowBits", 32'hFFD3_0291, 1'b0, decodePkg::clsOpImm, decodePkg::immI,
                 32'hFFFF_FFFD, 5'd5, decodePkg::brNone, decodePkg::sysNone, 1'b1);
        addEntry("ecall", 32'h0000_0073, 1'b0, decodePkg::clsSystem, decodePkg::immI,
                 32'h0000_0000, 5'd0, decodePkg::brNone, decodePkg::sysEcall, 1'b0);
        addEntry("ebreak", 32'h0010_0073, 1'b0, decodePkg::clsSystem, decodePkg::immI,
                 32'h0000_0001, 5'd0, decodePkg::brNone, decodePkg::sysEbreak, 1'b0);
        addEntry("mret", 32'h3020_0073, 1'b0, decodePkg::clsSystem, decodePkg::immI,
                 32'h0000_0302, 5'd0, decodePkg::brNone, decodePkg::sysMret, 1'b0);
        addEntry("fenceI", 32'h0000_100F, 1'b0, decodePkg::clsFence, decodePkg::immI,
                 32'h0000_0000, 5'd0, decodePkg::brNone, decodePkg::sysFenceI, 1'b0);
        addEntry("fence", 32'h0FF0_000F, 1'b0, decodePkg::clsFence, decodePkg::immI,
                 32'h0000_00FF, 5'd0, decodePkg::brNone, decodePkg::sysNone, 1'b1);
        addEntry("fetchErr", 32'hFFD3_0293, 1'b1, decodePkg::clsOpImm, decodePkg::immI,
                 32'hFFFF_FFFD, 5'd5, decodePkg::brNone, decodePkg::sysNone, 1'b0);
    endtask

    task automatic flagMismatch(input string test, input string field,
                                input logic [63:0] expV, input logic [63:0] actV);
        errors++;
        $display("FAIL %s %s expected %0h actual %0h", test, field, expV, actV);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abortRun(input string msg);
        errors++;
        $display("error: %s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped on a handshake error");
    endtask

    task automatic compareField(input int k, input string field,
                                input logic [63:0] expV, input logic [63:0] actV);
        assert (actV == expV) else flagMismatch(names[k], field, expV, actV);
    endtask

    task automatic verifyEntry(input int k);
        compareField(k, "pc", baseAddr + 64'(k) * 64'd4, outPc);
        compareField(k, "opClass", 64'(classTab[k]), 64'(outUop.opClass));
        compareField(k, "extOp", 64'(extTab[k]), 64'(outUop.extOp));
        compareField(k, "imm", 64'(immTab[k]), 64'(outUop.imm));
        compareField(k, "rd", 64'(rdTab[k]), 64'(outUop.rd));
        compareField(k, "branch", 64'(branchTab[k]), 64'(outUop.branch));
        compareField(k, "sysOp", 64'(sysTab[k]), 64'(outUop.sysOp));
        compareField(k, "illegal", 64'(illegalTab[k]), 64'(outUop.illegal));
        compareField(k, "fetchErr", 64'(fetchTab[k]), 64'(outUop.fetchErr));
    endtask

    initial begin : driveInputs
        logic gap;
        logic rdy;
        logic sent;
        rstN <= 1'b0;
        inValid <= 1'b0;
        inInstr <= '0;
        inPc <= '0;
        inFetchErr <= 1'b0;
        outReady <= 1'b0;
        lfsr = 16'd55;
        accepted = 0;
        loadTable();
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        forever begin
            @(negedge clk);
            sent = inValid && inReady; // transfer on the coming edge
            @(posedge clk);
            if (sent) begin
                accepted++;
            end
            takeBit(rdy);
            outReady <= rdy;
            if (inValid && !sent) begin
                // payload stays put until the DUT takes it
            end else if (accepted < numTests) begin
                takeBit(gap);
                inValid <= !gap;
                inInstr <= instrTab[accepted];
                inFetchErr <= fetchTab[accepted];
                inPc <= baseAddr + 64'(accepted) * 64'd4;
            end else begin
                inValid <= 1'b0;
            end
        end
    end

    initial begin : checkOutputs
        logic resetDone;
        resetDone = 1'b0;
        checked = 0;
        while (checked < numTests) begin
            @(negedge clk);
            if (accepted == 0) begin
                assert (!outValid)
                    else abortRun("outValid high before any instruction was accepted");
            end
            if (rstN && !resetDone) begin
                resetDone = 1'b1;
                assert (inReady) else abortRun("inReady low right after reset");
            end
            if (outValid && outReady) begin
                verifyEntry(checked);
                checked++;
            end
        end
        repeat (8) begin
            @(negedge clk);
            assert (!outValid) else abortRun("a micro-op came out after the last entry");
        end
        if (errors == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "%0d checks failed", errors);
        end
    end

    initial begin : watchdog
        wait (cycleCount >= timeoutCycles);
        $display("timeout after %0d cycles with %0d of %0d micro-ops checked",
                 cycleCount, checked, numTests);
        $display("TESTS FAILED");
        $fatal(1, "simulation did not finish in time");
    end

endmodule

`default_nettype wire

/* project.f */
common/decodePkg.sv
common/instrIf.sv
common/uopIf.sv
hw/decodeLane/immGen.sv
hw/decodeLane/controlDecode.sv
hw/decodeLane/decodeLane.sv
hw/laneDispatch.sv
hw/laneCollect.sv
hw/decodeTop.sv
test/decodeTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = decodeTb
FILELIST = project.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
